/* cam_pkg.sv */
package cam_pkg;

	// signed Q8.8 fixed point
	typedef logic signed [15:0] coord_t;

	// camera eye position
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vector_t;

	// one bit per held key, set on make and cleared on break
	typedef struct packed {
		logic fwd;
		logic back;
		logic left;
		logic right;
		logic up;
		logic down;
		logic render;
	} keys_t;

	// pixel coordinate sent down the pixel path
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} pixel_req_t;

	// scan code prefixes
	localparam logic [7:0] BREAK_CODE = 8'hF0;
	localparam logic [7:0] EXT_CODE   = 8'hE0;

	// set 2 scan codes, arrows only valid after EXT_CODE
	localparam logic [7:0] KEY_W     = 8'h1D;
	localparam logic [7:0] KEY_S     = 8'h1B;
	localparam logic [7:0] KEY_A     = 8'h1C;
	localparam logic [7:0] KEY_D     = 8'h23;
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_SPACE = 8'h29;

endpackage

/* ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx #(
	parameter int IDLE_LIMIT = 5000
) (
	input  logic       pkt_rec,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_dat,
	output logic [7:0] scan_code,
	output logic       code_valid,
	output logic       frame_err
);

	localparam int IW = $clog2(IDLE_LIMIT + 1);

	// two-flop synchronizers, clk_s3 is the previous value for edge detect
	logic clk_s1;
	logic clk_s2;
	logic clk_s3;
	logic dat_s1;
	logic dat_s2;

	logic          fall;
	logic [3:0]    bit_cnt;
	logic [IW-1:0] idle_cnt;

	// first ten bits of the frame, start bit ends up in bit 0
	logic [9:0]  shift_reg;
	logic [10:0] frame_w;
	logic        frame_ok;

	assign fall = clk_s3 & ~clk_s2;

	// incoming bit joins the ten already shifted in
	assign frame_w = {dat_s2, shift_reg};

	// start low, odd parity over data and parity bit, stop high
	assign frame_ok = ~frame_w[0] & (^frame_w[9:1]) & frame_w[10];

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			// lines idle high
			clk_s1 <= 1'b1;
			clk_s2 <= 1'b1;
			clk_s3 <= 1'b1;
			dat_s1 <= 1'b1;
			dat_s2 <= 1'b1;
			bit_cnt <= '0;
			idle_cnt <= '0;
			code_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			clk_s1 <= ps2_clk;
			clk_s2 <= clk_s1;
			clk_s3 <= clk_s2;
			dat_s1 <= ps2_dat;
			dat_s2 <= dat_s1;
			code_valid <= 1'b0;
			frame_err <= 1'b0;
			if (fall) begin
				idle_cnt <= '0;
				if (bit_cnt == 4'd10) begin
					// eleventh bit, check and report
					bit_cnt <= '0;
					if (frame_ok) begin
						code_valid <= 1'b1;
					end else begin
						frame_err <= 1'b1;
					end
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != 4'd0) begin
				// partial frame stalled, drop it quietly
				if (idle_cnt == IW'(IDLE_LIMIT - 1)) begin
					bit_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge pkt_rec) begin
		if (fall) begin
			shift_reg <= frame_w[10:1];
		end
		if (fall && bit_cnt == 4'd10) begin
			scan_code <= frame_w[8:1];
		end
	end

endmodule

/* key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
	input  logic           pkt_rec,
	input  logic           rst,
	input  logic [7:0]     scan_code,
	input  logic           code_valid,
	output cam_pkg::keys_t keys
);

	import cam_pkg::*;

	// prefixes seen since the last plain code
	logic break_pend;
	logic ext_pend;

	keys_t keys_next;

	// key state after applying the current code
	always_comb begin
		keys_next = keys;
		if (ext_pend) begin
			case (scan_code)
				KEY_UP: begin
					keys_next.up = ~break_pend;
				end
				KEY_DOWN: begin
					keys_next.down = ~break_pend;
				end
				default: begin
				end
			endcase
		end else begin
			case (scan_code)
				KEY_W: begin
					keys_next.fwd = ~break_pend;
				end
				KEY_S: begin
					keys_next.back = ~break_pend;
				end
				KEY_A: begin
					keys_next.left = ~break_pend;
				end
				KEY_D: begin
					keys_next.right = ~break_pend;
				end
				KEY_SPACE: begin
					keys_next.render = ~break_pend;
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			break_pend <= 1'b0;
			ext_pend <= 1'b0;
			keys <= '0;
		end else if (code_valid) begin
			if (scan_code == BREAK_CODE) begin
				break_pend <= 1'b1;
			end else if (scan_code == EXT_CODE) begin
				ext_pend <= 1'b1;
			end else begin
				// any plain code ends the prefix sequence
				break_pend <= 1'b0;
				ext_pend <= 1'b0;
				keys <= keys_next;
			end
		end
	end

endmodule

/* camera_ctrl.sv */
`timescale 1ns/1ps

module camera_ctrl #(
	parameter cam_pkg::coord_t STEP = 16'sd256
) (
	input  logic             pkt_rec,
	input  logic             rst,
	input  cam_pkg::keys_t   keys,
	input  logic             frame_done,
	output logic             render_frame,
	output cam_pkg::vector_t eye
);

	import cam_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_UPDATE,
		ST_START,
		ST_BUSY
	} state_t;

	state_t state;

	// keys that triggered this frame
	keys_t key_snap;

	// one axis of the step rule, opposite keys cancel
	function automatic coord_t axis_step(input logic pos, input logic neg);
		coord_t d;
		d = '0;
		if (pos && !neg) begin
			d = STEP;
		end else if (neg && !pos) begin
			d = -STEP;
		end
		return d;
	endfunction

	assign render_frame = (state == ST_START);

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			state <= ST_IDLE;
			eye <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (|keys) begin
						state <= ST_UPDATE;
					end
				end
				ST_UPDATE: begin
					// adds wrap in two's complement
					eye.x <= eye.x + axis_step(key_snap.right, key_snap.left);
					eye.y <= eye.y + axis_step(key_snap.up, key_snap.down);
					eye.z <= eye.z + axis_step(key_snap.fwd, key_snap.back);
					state <= ST_START;
				end
				ST_START: begin
					state <= ST_BUSY;
				end
				ST_BUSY: begin
					// wait for the scan, one step per frame
					if (frame_done) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge pkt_rec) begin
		if (state == ST_IDLE) begin
			key_snap <= keys;
		end
	end

endmodule

/* raster_scan.sv */
`timescale 1ns/1ps

module raster_scan #(
	parameter int H_RES = 640,
	parameter int V_RES = 480
) (
	input  logic                pkt_rec,
	input  logic                rst,
	input  logic                render_frame,
	input  logic                pix_stall,
	output cam_pkg::pixel_req_t pix,
	output logic                pix_valid,
	output logic                frame_done
);

	logic       busy;
	logic [9:0] x_cnt;
	logic [9:0] y_cnt;
	logic       last_x;
	logic       last_pix;

	assign last_x = (x_cnt == 10'(H_RES - 1));
	assign last_pix = last_x && (y_cnt == 10'(V_RES - 1));

	// stall holds the position and suppresses valid
	assign pix_valid = busy & ~pix_stall;
	assign pix.x = x_cnt;
	assign pix.y = y_cnt;

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			busy <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (!busy) begin
				if (render_frame) begin
					busy <= 1'b1;
					x_cnt <= '0;
					y_cnt <= '0;
				end
			end else if (pix_valid) begin
				if (last_pix) begin
					// done pulses the cycle after the last pixel
					busy <= 1'b0;
					frame_done <= 1'b1;
				end else if (last_x) begin
					x_cnt <= '0;
					y_cnt <= y_cnt + 10'd1;
				end else begin
					x_cnt <= x_cnt + 10'd1;
				end
			end
		end
	end

endmodule

/* cam_top.sv */
`timescale 1ns/1ps

module cam_top #(
	parameter cam_pkg::coord_t STEP = 16'sd256,
	parameter int H_RES = 640,
	parameter int V_RES = 480,
	// about 100 us of silence at 50 MHz
	parameter int IDLE_LIMIT = 5000
) (
	input  logic                pkt_rec,
	input  logic                rst,
	input  logic                ps2_clk,
	input  logic                ps2_dat,
	input  logic                pix_stall,
	output cam_pkg::keys_t      keys,
	output logic                frame_err,
	output cam_pkg::vector_t    eye,
	output logic                render_frame,
	output cam_pkg::pixel_req_t pix,
	output logic                pix_valid,
	output logic                frame_done
);

	logic [7:0] scan_code;
	logic       code_valid;

	ps2_rx #(
		.IDLE_LIMIT(IDLE_LIMIT)
	) u_rx (
		.pkt_rec(pkt_rec),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_dat(ps2_dat),
		.scan_code(scan_code),
		.code_valid(code_valid),
		.frame_err(frame_err)
	);

	key_decoder u_dec (
		.pkt_rec(pkt_rec),
		.rst(rst),
		.scan_code(scan_code),
		.code_valid(code_valid),
		.keys(keys)
	);

	camera_ctrl #(
		.STEP(STEP)
	) u_cam (
		.pkt_rec(pkt_rec),
		.rst(rst),
		.keys(keys),
		.frame_done(frame_done),
		.render_frame(render_frame),
		.eye(eye)
	);

	raster_scan #(
		.H_RES(H_RES),
		.V_RES(V_RES)
	) u_scan (
		.pkt_rec(pkt_rec),
		.rst(rst),
		.render_frame(render_frame),
		.pix_stall(pix_stall),
		.pix(pix),
		.pix_valid(pix_valid),
		.frame_done(frame_done)
	);

endmodule

/* cam_asserts.sv */
`timescale 1ns/1ps

module cam_asserts (
	input logic pkt_rec,
	input logic rst,
	input logic pix_valid,
	input logic pix_stall,
	input logic frame_done,
	input logic render_frame,
	input logic code_valid,
	input logic frame_err
);

	// scan in progress, from render_frame to frame_done
	logic scan_on;

	always_ff @(posedge pkt_rec) begin
		if (rst) begin
			scan_on <= 1'b0;
		end else if (render_frame) begin
			scan_on <= 1'b1;
		end else if (frame_done) begin
			scan_on <= 1'b0;
		end
	end

	a_no_valid_in_stall: assert property (@(posedge pkt_rec) disable iff (rst)
		!(pix_valid && pix_stall))
		else $error("pix_valid high during pix_stall");

	a_done_one_cycle: assert property (@(posedge pkt_rec) disable iff (rst)
		frame_done |=> !frame_done)
		else $error("frame_done longer than one cycle");

	a_no_render_in_scan: assert property (@(posedge pkt_rec) disable iff (rst)
		render_frame |-> !scan_on)
		else $error("render_frame while a scan is running");

	a_rx_exclusive: assert property (@(posedge pkt_rec) disable iff (rst)
		!(code_valid && frame_err))
		else $error("code_valid and frame_err high together");

endmodule

/* tb_cam.sv */
`timescale 1ns/1ps

module tb_cam;

	import cam_pkg::*;

	localparam int H_RES = 8;
	localparam int V_RES = 4;

	logic       pkt_rec = 1'b0;
	logic       rst = 1'b1;
	logic       ps2_clk = 1'b1;
	logic       ps2_dat = 1'b1;
	logic       pix_stall = 1'b1;
	keys_t      keys;
	logic       frame_err;
	vector_t    eye;
	logic       render_frame;
	pixel_req_t pix;
	logic       pix_valid;
	logic       frame_done;

	// parsed command list
	byte         cmd_q[$];
	logic [15:0] a_q[$];
	logic [15:0] b_q[$];
	logic [15:0] c_q[$];

	vector_t cap_q[$];
	keys_t   exp_keys = '0;
	logic    brk_seen = 1'b0;
	logic    ext_seen = 1'b0;
	logic    rand_stall = 1'b0;
	logic [31:0] rng = 32'h8f9f;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0;
	int ferr_cnt = 0;
	int done_cnt = 0;
	int px = 0;
	int py = 0;
	int pcount = 0;

	cam_top #(
		.STEP(16'sd256),
		.H_RES(H_RES),
		.V_RES(V_RES),
		.IDLE_LIMIT(200)
	) UUT (
		.pkt_rec(pkt_rec), .rst(rst), .ps2_clk(ps2_clk), .ps2_dat(ps2_dat),
		.pix_stall(pix_stall), .keys(keys), .frame_err(frame_err), .eye(eye),
		.render_frame(render_frame), .pix(pix), .pix_valid(pix_valid),
		.frame_done(frame_done)
	);

	bind cam_top cam_asserts u_asserts (
		.pkt_rec(pkt_rec), .rst(rst), .pix_valid(pix_valid), .pix_stall(pix_stall),
		.frame_done(frame_done), .render_frame(render_frame),
		.code_valid(code_valid), .frame_err(frame_err)
	);

	always #20 pkt_rec = ~pkt_rec;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// one cycle, inputs change 2 ns after the edge
	task automatic tick(input int n);
		repeat (n) begin
			@(posedge pkt_rec);
			#2;
			rng = xorshift(rng);
			pix_stall = rand_stall ? (rng[1:0] == 2'b00) : 1'b1;
		end
	endtask

	always @(posedge pkt_rec) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: run exceeded %0d cycles", limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge pkt_rec) begin
		if (!rst) begin
			if (frame_err)
				ferr_cnt++;
			if (render_frame) begin
				cap_q.push_back(eye);
				px = 0;
				py = 0;
				pcount = 0;
			end
			if (pix_valid) begin
				checks++;
				assert (pix.x == px && pix.y == py) else begin
					errors++;
					$display("Fail %0t: pixel (%0d,%0d), expected (%0d,%0d)",
						$time, pix.x, pix.y, px, py);
				end
				pcount++;
				px++;
				if (px == H_RES) begin
					px = 0;
					py++;
				end
			end
			if (frame_done) begin
				done_cnt++;
				checks++;
				assert (pcount == H_RES * V_RES) else begin
					errors++;
					$display("Fail %0t: frame had %0d pixels", $time, pcount);
				end
			end
		end
	end

	task automatic send_frame(input logic [7:0] code, input logic bad);
		logic [10:0] bits;
		bits = {1'b1, ~(^code) ^ bad, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_dat = bits[i];
			ps2_clk = 1'b1;
			tick(4);
			ps2_clk = 1'b0;
			tick(4);
		end
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		tick(8);
	endtask

	// reference decode of set 2 make and break codes
	task automatic model_code(input logic [7:0] code);
		if (code == 8'hF0) begin
			brk_seen = 1'b1;
		end else if (code == 8'hE0) begin
			ext_seen = 1'b1;
		end else begin
			if (ext_seen) begin
				if (code == 8'h75)
					exp_keys.up = ~brk_seen;
				if (code == 8'h72)
					exp_keys.down = ~brk_seen;
			end else begin
				case (code)
					8'h1D: exp_keys.fwd = ~brk_seen;
					8'h1B: exp_keys.back = ~brk_seen;
					8'h1C: exp_keys.left = ~brk_seen;
					8'h23: exp_keys.right = ~brk_seen;
					8'h29: exp_keys.render = ~brk_seen;
					default: ;
				endcase
			end
			brk_seen = 1'b0;
			ext_seen = 1'b0;
		end
	endtask

	task automatic load_file();
		int fd;
		int n;
		string line;
		byte c;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] d;
		fd = $fopen("cam_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open cam_testdata.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%c", c);
				a = 0;
				b = 0;
				d = 0;
				if (c == "W")
					n = $sscanf(line, "%c %d", c, a);
				else
					n = $sscanf(line, "%c %h %h %h", c, a, b, d);
				if (c == "K" || c == "B" || c == "W" || c == "E") begin
					cmd_q.push_back(c);
					a_q.push_back(a);
					b_q.push_back(b);
					c_q.push_back(d);
					if (c == "W")
						limit += a;
					else if (c == "E")
						limit += H_RES * V_RES * 4 + 50;
					else
						limit += 100;
				end
			end
		end
		$fclose(fd);
		limit = (limit + 10) * 2;
	endtask

	initial begin
		vector_t exp_eye;
		int f0;
		int d0;
		load_file();
		tick(2);
		rst = 1'b0;
		tick(2);
		foreach (cmd_q[i]) begin
			case (cmd_q[i])
				"K", "B": begin
					f0 = ferr_cnt;
					send_frame(a_q[i][7:0], cmd_q[i] == "B");
					if (cmd_q[i] == "K")
						model_code(a_q[i][7:0]);
					checks++;
					assert (ferr_cnt == f0 + (cmd_q[i] == "B")) else begin
						errors++;
						$display("Fail %0t: frame_err count %0d after code %h",
							$time, ferr_cnt, a_q[i][7:0]);
					end
					checks++;
					assert (keys == exp_keys) else begin
						errors++;
						$display("Fail %0t: keys %b, expected %b", $time, keys, exp_keys);
					end
				end
				"W": begin
					rand_stall = 1'b1;
					tick(a_q[i]);
					rand_stall = 1'b0;
					checks++;
					assert (cap_q.size() == 0) else begin
						errors++;
						$display("Fail %0t: render_frame during wait with no key held",
							$time);
						cap_q.delete();
					end
				end
				default: begin
					exp_eye.x = a_q[i];
					exp_eye.y = b_q[i];
					exp_eye.z = c_q[i];
					while (cap_q.size() == 0)
						tick(1);
					checks++;
					assert (cap_q[0] == exp_eye) else begin
						errors++;
						$display("Fail %0t: eye %h, expected %h", $time, cap_q[0], exp_eye);
					end
					void'(cap_q.pop_front());
					// let the scan run until its frame_done
					d0 = done_cnt;
					rand_stall = 1'b1;
					while (done_cnt == d0)
						tick(1);
					rand_stall = 1'b0;
				end
			endcase
		end
		tick(4);
		checks++;
		assert (cap_q.size() == 0) else begin
			errors++;
			$display("%0d render_frame pulses left without a matching E line", cap_q.size());
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* sim.f */
cam_pkg.sv
ps2_rx.sv
key_decoder.sv
camera_ctrl.sv
raster_scan.sv
cam_top.sv
cam_asserts.sv
tb_cam.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_cam
FILELIST  ?= sim.f
RTL_TOP   ?= cam_top
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* cam_testdata.txt */
# K code: good frame, B code: bad parity frame, W n: wait n cycles (decimal)
# E x y z: expected eye (hex) at the next render_frame
B 1D
K 75
W 40
K 1D
E 0000 0000 0100
E 0000 0000 0200
K F0
K 1D
E 0000 0000 0300
W 200
K 23
E 0100 0000 0300
K E0
K 75
E 0200 0000 0300
E 0300 0100 0300
K F0
K 23
K E0
K F0
K 75
E 0400 0200 0300
W 200
K 29
E 0400 0200 0300
K F0
K 29
E 0400 0200 0300
W 200
K 1C
K 1B
E 0300 0200 0300
E 0200 0200 0200
K F0
K 1C
K F0
K 1B
E 0100 0200 0100
W 200
